/* rtl/tcdm_cfg_pkg.sv */
package tcdm_cfg_pkg;

   // four masters share four word-interleaved banks
   localparam int unsigned NB_MASTERS = 4;
   localparam int unsigned NB_BANKS   = 4;

   // each bank holds 256 words, so the whole space is 4 KiB
   localparam int unsigned BANK_SIZE  = 256;
   localparam int unsigned BANK_SEL_W = 2;
   localparam int unsigned ROW_W      = 8;
   localparam int unsigned MST_SEL_W  = 2;

   // bus widths of the master port
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned BE_W   = 4;
   localparam int unsigned BYTE_W = 8;

   // in a byte address bits 1:0 are ignored, 3:2 pick the bank and 11:4 the row
   localparam int unsigned BANK_SEL_LSB = 2;
   localparam int unsigned ROW_LSB      = BANK_SEL_LSB + BANK_SEL_W;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     word_t;
   typedef logic [BE_W-1:0]       be_t;
   typedef logic [ROW_W-1:0]      row_t;
   typedef logic [BANK_SEL_W-1:0] bank_sel_t;
   typedef logic [MST_SEL_W-1:0]  mst_sel_t;

endpackage

/* rtl/tcdm_bus_pkg.sv */
package tcdm_bus_pkg;

   // request strobe from one master
   // wen high means read and wen low means write
   // the fields stay stable until gnt is seen in the same cycle
   typedef struct packed {
      logic                req;
      tcdm_cfg_pkg::addr_t add;
      logic                wen;
      tcdm_cfg_pkg::be_t   be;
      tcdm_cfg_pkg::word_t wdata;
   } tcdm_req_t;

   // response to one master
   // gnt is combinational, r_valid follows every grant by one cycle
   typedef struct packed {
      logic                gnt;
      logic                r_valid;
      tcdm_cfg_pkg::word_t r_rdata;
   } tcdm_rsp_t;

   // request as seen by a single bank after decode and arbitration
   // the row index replaces the byte address
   // byte enables are still active high here
   typedef struct packed {
      logic                req;
      tcdm_cfg_pkg::row_t  row;
      logic                wen;
      tcdm_cfg_pkg::be_t   be;
      tcdm_cfg_pkg::word_t wdata;
   } bank_req_t;

endpackage

/* rtl/tcdm_sram_bank.sv */
module tcdm_sram_bank (
   input  logic                clk_i,
   input  logic                ce_n,
   input  logic                we_n,
   input  tcdm_cfg_pkg::be_t   be_n,
   input  tcdm_cfg_pkg::row_t  a,
   input  tcdm_cfg_pkg::word_t d,
   output tcdm_cfg_pkg::word_t q
);

   // storage array, one word per row
   tcdm_cfg_pkg::word_t mem [tcdm_cfg_pkg::BANK_SIZE];

   // the single port allows one access per edge, either a write or a read
   always_ff @(posedge clk_i) begin
      if (!ce_n) begin
         if (!we_n) begin
            // only bytes with a low mask bit are written
            for (int b = 0; b < tcdm_cfg_pkg::BE_W; b++) begin
               if (!be_n[b]) begin
                  mem[a][b*tcdm_cfg_pkg::BYTE_W +: tcdm_cfg_pkg::BYTE_W] <=
                     d[b*tcdm_cfg_pkg::BYTE_W +: tcdm_cfg_pkg::BYTE_W];
               end
            end
         end else begin
            // read word is registered and held until the next read
            q <= mem[a];
         end
      end
   end

   // a selected bank must see a defined row address
   // otherwise a write lands on an unknown row
   a_addr_known : assert property (
      @(posedge clk_i) !ce_n |-> !$isunknown(a)
   ) else $error("tcdm_sram_bank: row address unknown while ce_n is low");

endmodule

/* rtl/tcdm_banks_wrap.sv */
module tcdm_banks_wrap (
   input  logic                    clk_i,
   input  tcdm_bus_pkg::bank_req_t bank_req   [tcdm_cfg_pkg::NB_BANKS],
   output tcdm_cfg_pkg::word_t     bank_rdata [tcdm_cfg_pkg::NB_BANKS]
);

   // one single-port macro per bank
   for (genvar i = 0; i < tcdm_cfg_pkg::NB_BANKS; i++) begin : g_bank

      logic                bank_ce_n;
      logic                bank_we_n;
      tcdm_cfg_pkg::be_t   bank_be_n;
      tcdm_cfg_pkg::row_t  bank_a;
      tcdm_cfg_pkg::word_t bank_d;
      tcdm_cfg_pkg::word_t bank_q;

      // the macro is active low on enable and byte mask
      assign bank_ce_n = ~bank_req[i].req;
      assign bank_be_n = ~bank_req[i].be;

      // wen already has write as its low level, so it goes straight through
      assign bank_we_n = bank_req[i].wen;

      assign bank_a = bank_req[i].row;
      assign bank_d = bank_req[i].wdata;

      // read word of this bank, valid the cycle after a read
      assign bank_rdata[i] = bank_q;

      tcdm_sram_bank u_bank (
         .clk_i ( clk_i     ),
         .ce_n  ( bank_ce_n ),
         .we_n  ( bank_we_n ),
         .be_n  ( bank_be_n ),
         .a     ( bank_a    ),
         .d     ( bank_d    ),
         .q     ( bank_q    )
      );

   end

endmodule

/* rtl/tcdm_rr_arbiter.sv */
module tcdm_rr_arbiter (
   input  logic                                clk_i,
   input  logic                                reset,
   input  logic [tcdm_cfg_pkg::NB_MASTERS-1:0] request,
   output logic [tcdm_cfg_pkg::NB_MASTERS-1:0] grant
);

   // master that has highest priority in the current cycle
   tcdm_cfg_pkg::mst_sel_t prio_q;

   // search result of the current cycle
   tcdm_cfg_pkg::mst_sel_t winner;
   tcdm_cfg_pkg::mst_sel_t cand;
   logic                   found;

   // walk the request vector once, starting at the priority pointer
   // the index wraps because the master count is a power of two
   always_comb begin
      grant  = '0;
      winner = prio_q;
      cand   = prio_q;
      found  = 1'b0;
      for (int i = 0; i < tcdm_cfg_pkg::NB_MASTERS; i++) begin
         cand = prio_q + tcdm_cfg_pkg::mst_sel_t'(i);
         if (!found && request[cand]) begin
            found  = 1'b1;
            winner = cand;
         end
      end
      grant[winner] = found;
   end

   // after a grant the master behind the winner gets first pick
   // so a waiting master is served within NB_MASTERS cycles
   always_ff @(posedge clk_i) begin
      if (reset) begin
         prio_q <= '0;
      end else if (found) begin
         prio_q <= winner + tcdm_cfg_pkg::mst_sel_t'(1);
      end
   end

   // never more than one winner, and only among the requesters
   a_grant_legal : assert property (
      @(posedge clk_i) disable iff (reset)
      $onehot0(grant) && ((grant & ~request) == '0)
   ) else $error("tcdm_rr_arbiter: grant %b illegal for request %b", grant, request);

endmodule

/* rtl/tcdm_xbar.sv */
module tcdm_xbar (
   input  logic                    clk_i,
   input  logic                    reset,
   input  tcdm_bus_pkg::tcdm_req_t mst_req    [tcdm_cfg_pkg::NB_MASTERS],
   output tcdm_bus_pkg::tcdm_rsp_t mst_rsp    [tcdm_cfg_pkg::NB_MASTERS],
   output tcdm_bus_pkg::bank_req_t bank_req   [tcdm_cfg_pkg::NB_BANKS],
   input  tcdm_cfg_pkg::word_t     bank_rdata [tcdm_cfg_pkg::NB_BANKS]
);

   // bank targeted by each master
   tcdm_cfg_pkg::bank_sel_t mst_bank [tcdm_cfg_pkg::NB_MASTERS];

   // per bank, which masters ask for it and which one won
   logic [tcdm_cfg_pkg::NB_MASTERS-1:0] bank_request [tcdm_cfg_pkg::NB_BANKS];
   logic [tcdm_cfg_pkg::NB_MASTERS-1:0] bank_grant   [tcdm_cfg_pkg::NB_BANKS];

   // grant seen by each master in this cycle
   logic [tcdm_cfg_pkg::NB_MASTERS-1:0] mst_gnt;

   // response state for the cycle after the grant
   logic [tcdm_cfg_pkg::NB_MASTERS-1:0] rsp_valid_q;
   tcdm_cfg_pkg::bank_sel_t             rsp_bank_q [tcdm_cfg_pkg::NB_MASTERS];

   // words are interleaved, so the low word address bits pick the bank
   // address bits above the row field are not decoded and alias
   always_comb begin
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         mst_bank[m] = mst_req[m].add[tcdm_cfg_pkg::BANK_SEL_LSB +: tcdm_cfg_pkg::BANK_SEL_W];
      end
   end

   // each bank only sees masters that address it
   always_comb begin
      for (int b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin
         for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
            bank_request[b][m] = mst_req[m].req &&
                                 (mst_bank[m] == tcdm_cfg_pkg::bank_sel_t'(b));
         end
      end
   end

   // each bank has its own round-robin arbiter and all of them work in parallel
   for (genvar b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin : g_arb
      tcdm_rr_arbiter u_arb (
         .clk_i   ( clk_i           ),
         .reset   ( reset           ),
         .request ( bank_request[b] ),
         .grant   ( bank_grant[b]   )
      );
   end

   // steer the winning master onto its bank
   // an idle bank gets an all-zero request
   always_comb begin
      for (int b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin
         bank_req[b] = '0;
         for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
            if (bank_grant[b][m]) begin
               bank_req[b].req   = 1'b1;
               bank_req[b].row   = mst_req[m].add[tcdm_cfg_pkg::ROW_LSB +: tcdm_cfg_pkg::ROW_W];
               bank_req[b].wen   = mst_req[m].wen;
               bank_req[b].be    = mst_req[m].be;
               bank_req[b].wdata = mst_req[m].wdata;
            end
         end
      end
   end

   // a master can win in at most one bank, so the OR over banks is its grant
   always_comb begin
      mst_gnt = '0;
      for (int b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin
         mst_gnt = mst_gnt | bank_grant[b];
      end
   end

   // every grant, read or write, produces one response pulse
   always_ff @(posedge clk_i) begin
      if (reset) begin
         rsp_valid_q <= '0;
      end else begin
         rsp_valid_q <= mst_gnt;
      end
   end

   // remember which bank will return the word
   always_ff @(posedge clk_i) begin
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         if (mst_gnt[m]) begin
            rsp_bank_q[m] <= mst_bank[m];
         end
      end
   end

   // bank output is already registered, so it is simply routed back
   always_comb begin
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         mst_rsp[m].gnt     = mst_gnt[m];
         mst_rsp[m].r_valid = rsp_valid_q[m];
         mst_rsp[m].r_rdata = bank_rdata[rsp_bank_q[m]];
      end
   end

   // response pulses must pair one to one with grants from the cycle before
   for (genvar m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin : g_chk
      a_rvalid_after_gnt : assert property (
         @(posedge clk_i) disable iff (reset)
         mst_rsp[m].r_valid |-> $past(mst_rsp[m].gnt)
      ) else $error("tcdm_xbar: r_valid on master %0d without a grant", m);
   end

endmodule

/* rtl/tcdm_subsystem_top.sv */
module tcdm_subsystem_top (
   input  logic                    clk_i,
   input  logic                    reset,
   input  tcdm_bus_pkg::tcdm_req_t mst_req [tcdm_cfg_pkg::NB_MASTERS],
   output tcdm_bus_pkg::tcdm_rsp_t mst_rsp [tcdm_cfg_pkg::NB_MASTERS]
);

   // one arbitrated request per bank
   tcdm_bus_pkg::bank_req_t bank_req [tcdm_cfg_pkg::NB_BANKS];

   // registered read word of each bank
   tcdm_cfg_pkg::word_t bank_rdata [tcdm_cfg_pkg::NB_BANKS];

   // decode, arbitration and response routing
   tcdm_xbar u_xbar (
      .clk_i      ( clk_i      ),
      .reset      ( reset      ),
      .mst_req    ( mst_req    ),
      .mst_rsp    ( mst_rsp    ),
      .bank_req   ( bank_req   ),
      .bank_rdata ( bank_rdata )
   );

   // the bank array keeps its contents across a reset
   tcdm_banks_wrap u_banks (
      .clk_i      ( clk_i      ),
      .bank_req   ( bank_req   ),
      .bank_rdata ( bank_rdata )
   );

endmodule

/* sim/tcdm_tb.sv */
module tcdm_tb;

   localparam int HALF_PERIOD    = 20;
   localparam int SAMPLE_DELAY   = 5;
   localparam int TIMEOUT_CYCLES = 50;

   // kinds of traffic a master driver can produce
   localparam int MODE_FILL  = 0;
   localparam int MODE_READ  = 1;
   localparam int MODE_MIXED = 2;
   localparam int MODE_BANK  = 3;

   logic clk;
   logic reset;

   tcdm_bus_pkg::tcdm_req_t mst_req [tcdm_cfg_pkg::NB_MASTERS];
   tcdm_bus_pkg::tcdm_rsp_t mst_rsp [tcdm_cfg_pkg::NB_MASTERS];

   // word model of the whole 4 KiB space that is written byte by byte
   tcdm_cfg_pkg::word_t model [1024];

   // expected response of each master for the cycle after its grant
   logic                pend_v    [tcdm_cfg_pkg::NB_MASTERS];
   logic                pend_rd   [tcdm_cfg_pkg::NB_MASTERS];
   tcdm_cfg_pkg::word_t pend_data [tcdm_cfg_pkg::NB_MASTERS];

   int seed;
   int mst_seed [tcdm_cfg_pkg::NB_MASTERS];
   int errors;
   int tests_passed;
   int tests_failed;
   int err_start;
   logic abort;

   tcdm_subsystem_top u_dut (
      .clk_i   ( clk     ),
      .reset   ( reset   ),
      .mst_req ( mst_req ),
      .mst_rsp ( mst_rsp )
   );

   always #HALF_PERIOD clk = ~clk;

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail at time %0t: %s is %h, expected %h", $time, sig, got, exp);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      errors++;
   endtask

   // master m issues one request that starts on a falling edge
   // returns on the falling edge after the transfer edge
   task automatic access(input int m, input tcdm_cfg_pkg::addr_t add, input logic wen,
                         input tcdm_cfg_pkg::be_t be, input tcdm_cfg_pkg::word_t wdata,
                         input int max_wait);
      int   waited;
      logic granted;
      waited  = 0;
      granted = 1'b0;
      mst_req[m].req   = 1'b1;
      mst_req[m].add   = add;
      mst_req[m].wen   = wen;
      mst_req[m].be    = be;
      mst_req[m].wdata = wdata;
      // fields are held until gnt shows up before a rising edge
      while (!granted && waited < TIMEOUT_CYCLES) begin
         #SAMPLE_DELAY;
         if (mst_rsp[m].gnt) begin
            granted = 1'b1;
         end else begin
            waited++;
            @(negedge clk);
         end
      end
      if (!granted) begin
         report_problem($sformatf("master %0d saw no gnt within %0d cycles", m, waited));
         abort = 1'b1;
      end else begin
         if (waited >= max_wait) begin
            report_problem($sformatf("master %0d waited %0d cycles for gnt, limit %0d",
                                     m, waited, max_wait - 1));
         end
         @(negedge clk);
      end
      mst_req[m].req = 1'b0;
   endtask

   // drives one master from its own random stream
   task automatic run_master(input int m, input int n_ops, input int mode,
                             input int bank_base, input int bank_step, input int max_wait);
      int                  s;
      int                  r;
      int                  idle;
      int                  bank;
      tcdm_cfg_pkg::addr_t add;
      logic                wen;
      tcdm_cfg_pkg::be_t   be;
      tcdm_cfg_pkg::word_t wdata;
      s    = mst_seed[m];
      bank = (bank_base + bank_step * m) % tcdm_cfg_pkg::NB_BANKS;
      for (int i = 0; i < n_ops && !abort; i++) begin
         add   = $random(s);
         wdata = $random(s);
         r     = $random(s);
         wen   = r[0];
         be    = r[7:4];
         idle  = 0;
         case (mode)
            MODE_FILL: begin
               // each master fills its own quarter with whole words
               add = (m * tcdm_cfg_pkg::BANK_SIZE + i) * 4;
               wen = 1'b0;
               be  = '1;
            end
            MODE_READ: wen = 1'b1;
            MODE_MIXED: idle = (r >> 8) & 3;
            MODE_BANK: add[3:2] = bank[1:0];
            default: ;
         endcase
         repeat (idle) @(negedge clk);
         access(m, add, wen, be, wdata, max_wait);
      end
      mst_seed[m] = s;
   endtask

   // all four drivers run side by side and the call starts on a falling edge
   task automatic run_all(input int mode, input int n_ops, input int bank_base,
                          input int bank_step, input int max_wait);
      fork
         run_master(0, n_ops, mode, bank_base, bank_step, max_wait);
         run_master(1, n_ops, mode, bank_base, bank_step, max_wait);
         run_master(2, n_ops, mode, bank_base, bank_step, max_wait);
         run_master(3, n_ops, mode, bank_base, bank_step, max_wait);
      join
   endtask

   task automatic end_test(input string name, input int first_err);
      // two more falling edges so the last responses get checked
      repeat (2) @(negedge clk);
      if (errors == first_err) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - first_err);
      end
   endtask

   // the monitor checks responses on the falling edge, then samples the
   // grants of the coming rising edge once the new inputs have settled
   always begin : monitor
      int gnt_per_bank [tcdm_cfg_pkg::NB_BANKS];
      @(negedge clk);
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         if (mst_rsp[m].r_valid !== pend_v[m]) begin
            report_mismatch($sformatf("mst_rsp[%0d].r_valid", m), 32'(mst_rsp[m].r_valid),
                            32'(pend_v[m]));
         end else if (pend_v[m] && pend_rd[m] && mst_rsp[m].r_rdata !== pend_data[m]) begin
            report_mismatch($sformatf("mst_rsp[%0d].r_rdata", m), mst_rsp[m].r_rdata,
                            pend_data[m]);
         end
         pend_v[m] = 1'b0;
      end
      #SAMPLE_DELAY;
      for (int b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin
         gnt_per_bank[b] = 0;
      end
      // reads take the model word as it stands before this edge
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         if (mst_rsp[m].gnt !== 1'b0) begin
            if (mst_req[m].req !== 1'b1) begin
               report_problem($sformatf("gnt on master %0d without a request", m));
            end
            gnt_per_bank[mst_req[m].add[3:2]]++;
            pend_v[m]    = 1'b1;
            pend_rd[m]   = mst_req[m].wen;
            pend_data[m] = model[mst_req[m].add[11:2]];
         end
      end
      // then the granted writes land, only on enabled bytes
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         if (mst_rsp[m].gnt === 1'b1 && mst_req[m].wen === 1'b0) begin
            for (int by = 0; by < 4; by++) begin
               if (mst_req[m].be[by]) begin
                  model[mst_req[m].add[11:2]][by*8 +: 8] = mst_req[m].wdata[by*8 +: 8];
               end
            end
         end
      end
      for (int b = 0; b < tcdm_cfg_pkg::NB_BANKS; b++) begin
         if (gnt_per_bank[b] > 1) begin
            report_problem($sformatf("bank %0d granted to %0d masters at once", b,
                                     gnt_per_bank[b]));
         end
      end
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      seed         = 32'h5434_dcc0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      abort        = 1'b0;
      for (int m = 0; m < tcdm_cfg_pkg::NB_MASTERS; m++) begin
         mst_req[m]  = '0;
         pend_v[m]   = 1'b0;
         pend_rd[m]  = 1'b0;
         pend_data[m] = '0;
         mst_seed[m] = seed + m;
      end

      // reset spans three rising edges and the monitor expects silence throughout
      err_start = errors;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);
      end_test("reset state", err_start);

      err_start = errors;
      run_all(MODE_FILL, tcdm_cfg_pkg::BANK_SIZE, 0, 0, tcdm_cfg_pkg::NB_MASTERS);
      end_test("fill", err_start);

      err_start = errors;
      run_all(MODE_READ, 64, 0, 0, tcdm_cfg_pkg::NB_MASTERS);
      end_test("read-back", err_start);

      err_start = errors;
      run_all(MODE_MIXED, 200, 0, 0, tcdm_cfg_pkg::NB_MASTERS);
      end_test("mixed traffic", err_start);

      // every master hammers bank 1 and round robin bounds each wait
      err_start = errors;
      run_all(MODE_BANK, 32, 1, 0, tcdm_cfg_pkg::NB_MASTERS);
      end_test("bank conflict", err_start);

      // each round gives every master a bank of its own, so all must win at once
      err_start = errors;
      for (int r = 0; r < 16 && !abort; r++) begin
         run_all(MODE_BANK, 1, r, 1, 1);
      end
      end_test("parallel banks", err_start);

      $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* src.f */
rtl/tcdm_cfg_pkg.sv
rtl/tcdm_bus_pkg.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_banks_wrap.sv
rtl/tcdm_rr_arbiter.sv
rtl/tcdm_xbar.sv
rtl/tcdm_subsystem_top.sv
sim/tcdm_tb.sv

/* run.sh */
#!/bin/sh
# build the TCDM testbench with Verilator and run it
# the run counts as good only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tcdm_tb -f src.f -o tcdm_sim \
   && ./obj_dir/tcdm_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
   && { echo "run.sh: simulation ok"; exit 0; } \
   || { echo "run.sh: simulation or build failed"; exit 1; }
